// File: hw/bp_pkg.sv
package bp_pkg;

    ///////////////////////////////////////////////////////////////////////
    // basic types
    ///////////////////////////////////////////////////////////////////////

    typedef logic [29:0] pc_t; // word address, group = two aligned words

    // branch kind stored per btb entry
    typedef enum logic [1:0] {
        br_none = 2'b00, // no branch, also reported on a miss
        br_cond = 2'b01, // conditional direct
        br_jump = 2'b10, // unconditional direct
        br_call = 2'b11  // call or indirect, target from last resolve
    } br_type_e;

    ///////////////////////////////////////////////////////////////////////
    // table words and interfaces
    ///////////////////////////////////////////////////////////////////////

    // one word of the btb data ram, 32 bits
    typedef struct packed {
        br_type_e br_type;
        pc_t      target;
    } btb_data_t;

    // resolved branch coming back from execute, 64 bits
    typedef struct packed {
        logic     valid;   // one-cycle strobe
        pc_t      pc;      // branch pc, bit 0 picks the bank
        br_type_e br_type;
        pc_t      target;
        logic     taken;   // resolved direction
    } btb_update_t;

    // lookup result of one bank, 33 bits
    typedef struct packed {
        logic     hit;
        br_type_e br_type; // br_none on miss
        pc_t      target;
    } btb_hit_t;

    // prediction handed to fetch, 34 bits
    typedef struct packed {
        pc_t      next_pc;
        logic     taken;
        logic     slot;    // which word of the group was taken
        br_type_e br_type;
    } fetch_pred_t;

endpackage

// File: hw/bp_ram.sv
`timescale 1ns/10ps

module bp_ram #(
    parameter int width = 32,
    parameter int depth = 128
) (
    input  logic                     clk,
    input  logic                     we,    // write strobe
    input  logic [$clog2(depth)-1:0] waddr,
    input  logic [width-1:0]         wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output logic [width-1:0]         rdata  // valid the cycle after raddr
);

    logic [width-1:0] mem [depth]; // no init, owner masks with valid bits

    // write port
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, returns old word when waddr == raddr
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

// File: hw/btb_bank.sv
`timescale 1ns/10ps

module btb_bank import bp_pkg::*; #(
    parameter int btb_depth = 128, // entries, power of two
    parameter int bank_id   = 0    // 0 = even word, 1 = odd word
) (
    input  logic        clk,
    input  logic        rstn,
    input  pc_t         pc,     // fetch pc, sampled every edge
    input  btb_update_t update, // resolved branch
    output btb_hit_t    result  // valid one cycle after pc
);

    localparam int index_width = $clog2(btb_depth);
    localparam int tag_width   = 29 - index_width; // bits above the index

    logic [btb_depth-1:0]   valid;      // per entry valid, cleared on reset
    logic                   valid_q;    // valid bit of the looked-up entry
    logic [tag_width-1:0]   tag_q;      // lookup tag, aligned with ram read
    logic [tag_width-1:0]   tag_rd;     // stored tag
    btb_data_t              data_rd;    // stored type and target
    btb_data_t              data_wr;
    logic [index_width-1:0] lookup_idx;
    logic [index_width-1:0] upd_idx;
    logic                   bank_we;    // update belongs to this bank
    logic                   tag_match;

    ///////////////////////////////////////////////////////////////////////
    // index and write control
    ///////////////////////////////////////////////////////////////////////

    assign lookup_idx = pc[index_width:1];        // same index in both banks
    assign upd_idx    = update.pc[index_width:1];
    assign bank_we    = update.valid && (update.pc[0] == bank_id[0]); // parity check

    assign data_wr.br_type = update.br_type;
    assign data_wr.target  = update.target;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            valid   <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= valid[lookup_idx]; // old value on same-edge update
            if (bank_we)
            begin
                valid[upd_idx] <= 1'b1;
            end
        end
    end

    // lookup tag follows the ram read by one edge
    always_ff @(posedge clk)
    begin
        tag_q <= pc[29:index_width+1];
    end

    ///////////////////////////////////////////////////////////////////////
    // storage
    ///////////////////////////////////////////////////////////////////////

    bp_ram #(
        .width (tag_width),
        .depth (btb_depth)
    ) i_tag_ram (
        .clk   (clk),
        .we    (bank_we),
        .waddr (upd_idx),
        .wdata (update.pc[29:index_width+1]),
        .raddr (lookup_idx),
        .rdata (tag_rd)
    );

    bp_ram #(
        .width ($bits(btb_data_t)),
        .depth (btb_depth)
    ) i_data_ram (
        .clk   (clk),
        .we    (bank_we),
        .waddr (upd_idx),
        .wdata (data_wr),
        .raddr (lookup_idx),
        .rdata (data_rd)
    );

    ///////////////////////////////////////////////////////////////////////
    // hit compare
    ///////////////////////////////////////////////////////////////////////

    assign tag_match = (tag_rd == tag_q);

    always_comb
    begin
        result.hit = valid_q && tag_match; // valid masks uninit ram words
        if (result.hit)
        begin
            result.br_type = data_rd.br_type;
            result.target  = data_rd.target;
        end
        else
        begin
            result.br_type = br_none; // miss
            result.target  = '0;
        end
    end

    // back end only resolves real branches into the table
    a_no_none_update : assert property (
        @(posedge clk) disable iff (!rstn)
        bank_we |-> (update.br_type != br_none)
    );

endmodule

// File: hw/bht_counters.sv
`timescale 1ns/10ps

module bht_counters import bp_pkg::*; #(
    parameter int bht_depth = 256 // counter pairs, power of two
) (
    input  logic        clk,
    input  logic        rstn,
    input  pc_t         pc,
    input  btb_update_t update,
    output logic [1:0]  dir_taken // msb of each counter, slot order
);

    localparam int idx_width = $clog2(bht_depth);

    logic [1:0]           cnt [bht_depth][2]; // flops so reset can preset
    logic [idx_width-1:0] rd_idx;
    logic [idx_width-1:0] upd_idx;
    logic                 upd_slot;          // even or odd word of the group
    logic                 upd_en;
    logic [1:0]           cnt_cur;
    logic [1:0]           cnt_next;

    assign rd_idx   = pc[idx_width:1];
    assign upd_idx  = update.pc[idx_width:1];
    assign upd_slot = update.pc[0];
    assign upd_en   = update.valid && (update.br_type == br_cond); // cond only

    ///////////////////////////////////////////////////////////////////////
    // saturating step
    ///////////////////////////////////////////////////////////////////////

    always_comb
    begin
        cnt_cur  = cnt[upd_idx][upd_slot];
        cnt_next = cnt_cur;
        if (update.taken)
        begin
            if (cnt_cur != 2'd3)
                cnt_next = cnt_cur + 2'd1;
        end
        else
        begin
            if (cnt_cur != 2'd0)
                cnt_next = cnt_cur - 2'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < bht_depth; i++)
            begin
                cnt[i][0] <= 2'b01; // weakly not-taken
                cnt[i][1] <= 2'b01;
            end
            dir_taken <= 2'b00;
        end
        else
        begin
            // read sees the pre-update counter on a collision
            dir_taken <= {cnt[rd_idx][1][1], cnt[rd_idx][0][1]};
            if (upd_en)
            begin
                cnt[upd_idx][upd_slot] <= cnt_next;
            end
        end
    end

    // counters saturate at both ends
    a_inc_saturates : assert property (
        @(posedge clk) disable iff (!rstn)
        (upd_en && update.taken && cnt_cur == 2'd3)
            |=> (cnt[$past(upd_idx)][$past(upd_slot)] == 2'd3)
    );

    a_dec_saturates : assert property (
        @(posedge clk) disable iff (!rstn)
        (upd_en && !update.taken && cnt_cur == 2'd0)
            |=> (cnt[$past(upd_idx)][$past(upd_slot)] == 2'd0)
    );

endmodule

// File: hw/next_pc_select.sv
`timescale 1ns/10ps

module next_pc_select import bp_pkg::*; (
    input  logic           clk,
    input  logic           rstn,
    input  pc_t            pc,        // fetch pc, same edge as bank reads
    input  btb_hit_t [1:0] slot_hit,  // bank results, index = slot
    input  logic [1:0]     dir_taken, // counter msbs, index = slot
    output fetch_pred_t    pred
);

    pc_t        pc_q;       // lookup pc, lines up with ram outputs
    pc_t        group_base; // even word of the group
    logic [1:0] live;       // slot not skipped by an odd entry pc
    logic [1:0] take;       // slot predicted taken

    always_ff @(posedge clk)
    begin
        if (!rstn)
            pc_q <= '0; // gives next_pc = 2 out of reset
        else
            pc_q <= pc;
    end

    assign group_base = {pc_q[29:1], 1'b0};

    ///////////////////////////////////////////////////////////////////////
    // per-slot taken decision
    ///////////////////////////////////////////////////////////////////////

    assign live[0] = !pc_q[0]; // odd entry starts past slot 0
    assign live[1] = 1'b1;

    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            take[s] = 1'b0;
            if (live[s] && slot_hit[s].hit)
            begin
                case (slot_hit[s].br_type)
                    br_jump, br_call: take[s] = 1'b1;        // always redirect
                    br_cond:          take[s] = dir_taken[s];
                    default:          take[s] = 1'b0;
                endcase
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // first taken slot wins
    ///////////////////////////////////////////////////////////////////////

    always_comb
    begin
        pred.taken = |take;
        if (take[0])
        begin
            pred.next_pc = slot_hit[0].target;
            pred.slot    = 1'b0;
            pred.br_type = slot_hit[0].br_type;
        end
        else if (take[1])
        begin
            pred.next_pc = slot_hit[1].target;
            pred.slot    = 1'b1;
            pred.br_type = slot_hit[1].br_type;
        end
        else
        begin
            pred.next_pc = group_base + 30'd2; // sequential, next group
            pred.slot    = 1'b0;
            pred.br_type = br_none;
        end
    end

    // a taken prediction always comes from a real btb entry
    a_taken_has_type : assert property (
        @(posedge clk) disable iff (!rstn)
        pred.taken |-> (pred.br_type != br_none)
    );

endmodule

// File: hw/fetch_predictor.sv
`timescale 1ns/10ps

module fetch_predictor import bp_pkg::*; #(
    parameter int btb_depth = 128, // entries per bank
    parameter int bht_depth = 256  // counter pairs
) (
    input  logic        clk,
    input  logic        rstn,
    input  pc_t         pc,     // fetch pc, level
    input  btb_update_t update, // strobe when update.valid
    output fetch_pred_t pred    // one cycle after pc
);

    btb_hit_t [1:0] slot_hit;  // bank results, index = slot
    logic [1:0]     dir_taken; // counter msbs per slot

    ///////////////////////////////////////////////////////////////////////
    // target buffers, one bank per word of the group
    ///////////////////////////////////////////////////////////////////////

    btb_bank #(
        .btb_depth (btb_depth),
        .bank_id   (0)
    ) i_bank0 (
        .clk    (clk),
        .rstn   (rstn),
        .pc     (pc),
        .update (update),
        .result (slot_hit[0])
    );

    btb_bank #(
        .btb_depth (btb_depth),
        .bank_id   (1)
    ) i_bank1 (
        .clk    (clk),
        .rstn   (rstn),
        .pc     (pc),
        .update (update),
        .result (slot_hit[1])
    );

    ///////////////////////////////////////////////////////////////////////
    // direction and next pc
    ///////////////////////////////////////////////////////////////////////

    bht_counters #(
        .bht_depth (bht_depth)
    ) i_bht (
        .clk       (clk),
        .rstn      (rstn),
        .pc        (pc),
        .update    (update),
        .dir_taken (dir_taken)
    );

    next_pc_select i_select (
        .clk       (clk),
        .rstn      (rstn),
        .pc        (pc),
        .slot_hit  (slot_hit),
        .dir_taken (dir_taken),
        .pred      (pred)
    );

endmodule

// File: tests/fetch_predictor_tb.sv
`timescale 1ns/10ps

module fetch_predictor_tb import bp_pkg::*; ();

    localparam time drive_dly = 10ns; // inputs change this long after the edge

    typedef enum logic [1:0] {
        row_update,
        row_lookup,
        row_reset
    } row_kind_e;

    logic        clk;
    logic        rstn;
    pc_t         pc;
    btb_update_t update;
    fetch_pred_t pred;

    // stimulus table, one entry per row in each queue
    string       row_name[$];
    row_kind_e   row_kind[$];
    pc_t         row_pc[$];
    br_type_e    row_type[$];
    pc_t         row_target[$];
    logic        row_taken[$];
    fetch_pred_t row_exp[$];

    int     num_rows    = 0;
    int     cycle_count = 0;
    int     n_tests     = 0;
    int     n_errors    = 0;
    integer seed        = 68260;

    fetch_predictor i_dut (
        .clk    (clk),
        .rstn   (rstn),
        .pc     (pc),
        .update (update),
        .pred   (pred)
    );

    initial
    begin
        clk = 1'b0;
        forever #50ns clk = ~clk; // 100 ns period
    end

    // run limit grows with the table
    always @(posedge clk)
    begin
        cycle_count++;
        if (num_rows > 0 && cycle_count > 4 * num_rows + 20)
        begin
            $display("Timeout: run went past %0d cycles", 4 * num_rows + 20);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // expected values and table building
    ///////////////////////////////////////////////////////////////////////

    // no taken slot, fetch steps to the next group
    function automatic fetch_pred_t seq_pred(input pc_t p);
        fetch_pred_t e;
        e.next_pc = {p[29:1], 1'b0} + 30'd2;
        e.taken   = 1'b0;
        e.slot    = 1'b0;
        e.br_type = br_none;
        return e;
    endfunction

    function automatic fetch_pred_t taken_pred(input pc_t tgt, input logic s, input br_type_e t);
        fetch_pred_t e;
        e.next_pc = tgt;
        e.taken   = 1'b1;
        e.slot    = s;
        e.br_type = t;
        return e;
    endfunction

    task automatic push_row(input string name, input row_kind_e kind, input pc_t p,
                            input br_type_e t, input pc_t tgt, input logic tk,
                            input fetch_pred_t exp);
        row_name.push_back(name);
        row_kind.push_back(kind);
        row_pc.push_back(p);
        row_type.push_back(t);
        row_target.push_back(tgt);
        row_taken.push_back(tk);
        row_exp.push_back(exp);
    endtask

    task automatic record_update(input string name, input pc_t p, input br_type_e t,
                                 input pc_t tgt, input logic tk);
        push_row(name, row_update, p, t, tgt, tk, '0);
    endtask

    task automatic expect_lookup(input string name, input pc_t p, input fetch_pred_t exp);
        push_row(name, row_lookup, p, br_none, '0, 1'b0, exp);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // driving and checking
    ///////////////////////////////////////////////////////////////////////

    // one-cycle strobe, seen by the edge after it is driven
    task automatic apply_update(input pc_t p, input br_type_e t, input pc_t tgt, input logic tk);
        update.valid   = 1'b1;
        update.pc      = p;
        update.br_type = t;
        update.target  = tgt;
        update.taken   = tk;
        @(posedge clk);
        #drive_dly;
        update.valid = 1'b0;
    endtask

    // fields of one prediction as text
    function automatic string format_pred(input fetch_pred_t p);
        return $sformatf("next_pc=%h taken=%b slot=%b type=%0d",
                         p.next_pc, p.taken, p.slot, p.br_type);
    endfunction

    task automatic check_pred(input string name, input fetch_pred_t exp, input fetch_pred_t act);
        n_tests++;
        if (act !== exp)
        begin
            n_errors++;
            $display("Mismatch %s: expected %s, actual %s",
                     name, format_pred(exp), format_pred(act));
        end
        else
            $display("ok   %s", name);
    endtask

    initial
    begin
        pc_t r;
        pc_t r2;
        pc_t t1;
        pc_t t2;

        rstn   = 1'b0;
        pc     = '0;
        update = '0;

        // 1: misses, random pcs live above all trained ones
        expect_lookup("miss_even", 30'h040, seq_pred(30'h040));
        expect_lookup("miss_odd", 30'h041, seq_pred(30'h041));
        for (int i = 0; i < 4; i++)
        begin
            r     = $random(seed);
            r[29] = 1'b1;
            expect_lookup($sformatf("miss_rand_%0d", i), r, seq_pred(r));
        end

        // 2: unconditional, odd pc goes through bank 1
        record_update("upd_jump", 30'h100, br_jump, 30'h3000, 1'b1);
        expect_lookup("jump_even", 30'h100, taken_pred(30'h3000, 1'b0, br_jump));
        record_update("upd_call", 30'h205, br_call, 30'h1234, 1'b1);
        expect_lookup("call_group", 30'h204, taken_pred(30'h1234, 1'b1, br_call));
        expect_lookup("call_odd", 30'h205, taken_pred(30'h1234, 1'b1, br_call));

        // 3: counter 01 -> 00 -> 00 -> 01 -> 10 -> 11 -> 11 -> 10 -> 01
        record_update("cond_insert_nt", 30'h310, br_cond, 30'h500, 1'b0);
        record_update("cond_nt_sat", 30'h310, br_cond, 30'h500, 1'b0); // stuck at 00
        expect_lookup("cond_cnt0", 30'h310, seq_pred(30'h310));
        record_update("cond_t1", 30'h310, br_cond, 30'h500, 1'b1);
        expect_lookup("cond_cnt1", 30'h310, seq_pred(30'h310));
        record_update("cond_t2", 30'h310, br_cond, 30'h500, 1'b1);
        expect_lookup("cond_cnt2", 30'h310, taken_pred(30'h500, 1'b0, br_cond));
        record_update("cond_t3", 30'h310, br_cond, 30'h500, 1'b1);
        expect_lookup("cond_cnt3", 30'h310, taken_pred(30'h500, 1'b0, br_cond));
        record_update("cond_t_sat", 30'h310, br_cond, 30'h500, 1'b1); // stuck at 11
        expect_lookup("cond_sat3", 30'h310, taken_pred(30'h500, 1'b0, br_cond));
        record_update("cond_nt1", 30'h310, br_cond, 30'h500, 1'b0);
        expect_lookup("cond_back2", 30'h310, taken_pred(30'h500, 1'b0, br_cond));
        record_update("cond_nt2", 30'h310, br_cond, 30'h500, 1'b0);
        expect_lookup("cond_back1", 30'h310, seq_pred(30'h310));

        // 4: both slots taken
        record_update("upd_slot0", 30'h420, br_jump, 30'h800, 1'b1);
        record_update("upd_slot1", 30'h421, br_call, 30'h900, 1'b1);
        expect_lookup("prio_slot0", 30'h420, taken_pred(30'h800, 1'b0, br_jump));
        expect_lookup("prio_odd_skip", 30'h421, taken_pred(30'h900, 1'b1, br_call));

        // 5: odd entry r in bank 1, even entry r2 in bank 0 at another index
        r      = $random(seed);
        r[29]  = 1'b0;
        r[28]  = 1'b1;
        r[0]   = 1'b1;
        r2     = (r + 30'd4) & ~30'd1;
        t1     = $random(seed);
        t2     = $random(seed);
        record_update("sep_upd_odd", r, br_jump, t1, 1'b1);
        expect_lookup("sep_bank0_clean", r & ~30'd1, taken_pred(t1, 1'b1, br_jump));
        expect_lookup("sep_tag_miss", r ^ (30'd1 << 20), seq_pred(r ^ (30'd1 << 20)));
        record_update("sep_upd_replace", r, br_jump, t2, 1'b1);
        expect_lookup("sep_replaced", r, taken_pred(t2, 1'b1, br_jump));
        record_update("sep_upd_even", r2, br_call, t1, 1'b1);
        expect_lookup("sep_even_hit", r2, taken_pred(t1, 1'b0, br_call));
        expect_lookup("sep_bank1_clean", r2 | 30'd1, seq_pred(r2 | 30'd1));

        // 6: mid-run reset wipes the tables
        push_row("mid_reset", row_reset, '0, br_none, '0, 1'b0, '0);
        expect_lookup("reset_jump", 30'h100, seq_pred(30'h100));
        expect_lookup("reset_call", 30'h205, seq_pred(30'h205));
        expect_lookup("reset_slot0", 30'h420, seq_pred(30'h420));

        num_rows = row_name.size();

        // power-on reset
        repeat (3) @(posedge clk);
        #drive_dly;
        rstn = 1'b1;
        check_pred("reset_state", seq_pred('0), pred); // lookup pc cleared to 0

        ///////////////////////////////////////////////////////////////////////
        // table loop, every row starts and ends just after an edge
        ///////////////////////////////////////////////////////////////////////

        for (int i = 0; i < num_rows; i++)
        begin
            case (row_kind[i])
                row_update:
                    apply_update(row_pc[i], row_type[i], row_target[i], row_taken[i]);
                row_lookup:
                begin
                    pc = row_pc[i];
                    @(posedge clk); // pc sampled here
                    #drive_dly;
                    check_pred(row_name[i], row_exp[i], pred);
                end
                default:
                begin
                    rstn = 1'b0;
                    repeat (3) @(posedge clk);
                    #drive_dly;
                    rstn = 1'b1;
                end
            endcase
        end

        $display("tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_errors, n_errors);
        if (n_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: fetch_predictor.f
hw/bp_pkg.sv
hw/bp_ram.sv
hw/btb_bank.sv
hw/bht_counters.sv
hw/next_pc_select.sv
hw/fetch_predictor.sv
tests/fetch_predictor_tb.sv
